//--- vlog.f
hdl/fpmul_pkg.sv
hdl/fpmul_ctrl.sv
hdl/iter_counter.sv
hdl/fp_unpack.sv
hdl/man_shift_add.sv
hdl/fp_norm_round.sv
hdl/fpmul_top.sv
tb/tb_fpmul.sv

//--- run.sh
#!/bin/sh
# build and run the fp32 multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_fpmul -f vlog.f -o tb_fpmul > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_fpmul > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

//--- tb/tb_fpmul.sv
`default_nettype none

module tb_fpmul;

    localparam int n_dir   = 24;
    localparam int n_rand  = 2000;
    localparam int n_ops   = n_dir + n_rand;
    localparam int latency = 26;        // accepting edge to done

    // directed operand pairs covering exact, tie, carry out, special and range cases
    localparam logic [31:0] dir_a [n_dir] = '{
        32'h3fc0_0000, 32'hc040_0000, 32'h3f80_0000, 32'h3f80_0800,
        32'h3f80_0800, 32'h3fff_ffff, 32'h3f7f_ffff, 32'h3fff_fffe,
        32'h7fc0_0000, 32'hff80_0001, 32'h7f80_0000, 32'h7f80_0000,
        32'hff80_0000, 32'h0000_0000, 32'h8000_0000, 32'h0040_0000,
        32'h3f80_0000, 32'h7f7f_ffff, 32'hff00_0000, 32'h0080_0000,
        32'h0080_0000, 32'h0080_0001, 32'h00ff_ffff, 32'h0f80_0000
    };
    localparam logic [31:0] dir_b [n_dir] = '{
        32'h4000_0000, 32'h3e80_0000, 32'h3f80_0000, 32'h3f80_0800,
        32'h3f80_1800, 32'h3fff_ffff, 32'h3f80_0001, 32'h3f80_0001,
        32'h3f80_0000, 32'h0000_0000, 32'h0000_0000, 32'hc000_0000,
        32'hff80_0000, 32'hc040_0000, 32'h8000_0000, 32'h3f80_0000,
        32'h807f_ffff, 32'h4000_0000, 32'h7f00_0000, 32'h3f00_0000,
        32'h0080_0000, 32'h3f7f_ffff, 32'h3f00_0000, 32'h3000_0000
    };

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic        busy;
    logic        done;
    logic [31:0] result;

    logic [31:0] exp_q [$];
    logic [31:0] a_q [$];
    logic [31:0] b_q [$];
    int          start_q [$];

    int          cyc = 0;
    int          val_errs = 0;
    int          proto_errs = 0;
    int unsigned seed_dummy;
    logic        after_done = 1'b0;
    logic [31:0] chk_exp;
    logic [31:0] chk_a;
    logic [31:0] chk_b;
    int          chk_t0;

    fpmul_top fpmul_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op_a   (op_a),
        .op_b   (op_b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // binary32 product with subnormal inputs flushed and round to nearest even
    function automatic logic [31:0] ref_fmul(input logic [31:0] a, input logic [31:0] b);
        logic        sgn;
        logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
        int          ea, eb, e, msb, drop;
        logic [63:0] p, kept, rem, half;
        sgn    = a[31] ^ b[31];
        ea     = int'(a[30:23]);
        eb     = int'(b[30:23]);
        a_zero = (ea == 0);
        b_zero = (eb == 0);
        a_inf  = (ea == 255) && (a[22:0] == 23'd0);
        b_inf  = (eb == 255) && (b[22:0] == 23'd0);
        a_nan  = (ea == 255) && !a_inf;
        b_nan  = (eb == 255) && !b_inf;
        if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf))
            return 32'h7fc0_0000;
        if (a_inf || b_inf)
            return {sgn, 8'hff, 23'd0};
        if (a_zero || b_zero)
            return {sgn, 31'd0};
        p    = {40'd0, 1'b1, a[22:0]} * {40'd0, 1'b1, b[22:0]};
        msb  = p[47] ? 47 : 46;
        e    = msb + ea + eb - 173;   // biased exponent of the exact value
        drop = msb - 23;              // keep 24 bits
        if (e < 1) begin
            drop = drop + 1 - e;      // fixed 2^-149 scale
            e = 0;
        end
        if (drop > 49)
            drop = 49;                // whole product under half an ulp
        kept = p >> drop;
        rem  = p & ((64'd1 << drop) - 64'd1);
        half = 64'd1 << (drop - 1);
        if (rem > half || (rem == half && kept[0]))
            kept = kept + 64'd1;
        if (e == 0) begin
            if (kept[23])
                e = 1;                // rounded up to the smallest normal
        end else if (kept[24]) begin
            e = e + 1;
            kept = kept >> 1;
        end
        if (e >= 255)
            return {sgn, 8'hff, 23'd0};
        return {sgn, e[7:0], kept[22:0]};
    endfunction

    // mostly mid-range exponents and now and then a fully random word
    function automatic logic [31:0] rand_operand();
        logic [31:0] w;
        int unsigned r;
        w = $urandom;
        if (($urandom % 8) != 0) begin
            r = 64 + ($urandom % 128);
            w[30:23] = r[7:0];
        end
        return w;
    endfunction

    task automatic issue_op(input logic [31:0] a, input logic [31:0] b, input bit intrude);
        @(negedge clk);
        while (busy || done)
            @(negedge clk);
        start = 1'b1;
        op_a  = a;
        op_b  = b;
        exp_q.push_back(ref_fmul(a, b));
        a_q.push_back(a);
        b_q.push_back(b);
        start_q.push_back(cyc + 1);
        @(negedge clk);
        start = 1'b0;
        op_a  = $urandom;   // operands only matter on the accepting edge
        op_b  = $urandom;
        if (intrude) begin
            repeat (5) @(negedge clk);
            start = 1'b1;   // must be ignored while the unit is busy
            op_a  = ~a;
            op_b  = 32'h3f80_0000;
            @(negedge clk);
            start = 1'b0;
        end
    endtask

    initial begin : stimulus
        start = 1'b0;
        op_a  = 32'd0;
        op_b  = 32'd0;
        rst_n = 1'b0;
        seed_dummy = $urandom(32'hc67c_8b7d);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!busy && !done && result == 32'd0) else begin
            $display("busy, done or result not cleared after reset at %0t", $time);
            proto_errs++;
        end
        for (int i = 0; i < n_dir; i++)
            issue_op(dir_a[i], dir_b[i], (i % 8) == 1);
        for (int i = 0; i < n_rand; i++)
            issue_op(rand_operand(), rand_operand(), (i % 100) == 7);
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
        $display("closing: %0d operations, %0d result errors, %0d protocol errors",
                 n_ops, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial begin : compare
        forever begin
            @(negedge clk);
            if (after_done) begin
                assert (!busy) else begin
                    $display("busy is high one cycle after done at %0t", $time);
                    proto_errs++;
                end
            end
            after_done = done;
            if (done) begin
                if (exp_q.size() == 0) begin
                    $display("done pulse at %0t with no operation pending", $time);
                    proto_errs++;
                end else begin
                    chk_exp = exp_q.pop_front();
                    chk_a   = a_q.pop_front();
                    chk_b   = b_q.pop_front();
                    chk_t0  = start_q.pop_front();
                    assert (result == chk_exp) else begin
                        $display("ERR %0t: a=%h b=%h result=%h expected=%h",
                                 $time, chk_a, chk_b, result, chk_exp);
                        val_errs++;
                    end
                    assert (cyc - chk_t0 == latency) else begin
                        $display("done came %0d cycles after start instead of %0d at %0t",
                                 cyc - chk_t0, latency, $time);
                        proto_errs++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat ((n_ops + 10) * 30) @(posedge clk);
        $display("timeout: operations still pending after %0d cycles", (n_ops + 10) * 30);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/fpmul_top.sv
`default_nettype none

module fpmul_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [31:0] op_a,
    input  logic [31:0] op_b,
    output logic        busy,
    output logic        done,
    output logic [31:0] result
);
    import fpmul_pkg::*;

    logic              load;
    logic              run;
    logic              norm_en;
    logic              last;
    logic [sig_w-1:0]  sig_a;
    logic [sig_w-1:0]  sig_b;
    logic              res_sign;
    logic signed [9:0] exp_sum;
    special_t          spec;
    logic [prod_w-1:0] prod;

    fpmul_ctrl fpmul_ctrl_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .last    (last),
        .load    (load),
        .run     (run),
        .norm_en (norm_en),
        .busy    (busy),
        .done    (done)
    );

    iter_counter iter_counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .run   (run),
        .last  (last)
    );

    fp_unpack fp_unpack_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .op_a     (op_a),
        .op_b     (op_b),
        .sig_a    (sig_a),
        .sig_b    (sig_b),
        .res_sign (res_sign),
        .exp_sum  (exp_sum),
        .spec     (spec)
    );

    man_shift_add man_shift_add_i (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .run   (run),
        .sig_a (sig_a),
        .sig_b (sig_b),
        .prod  (prod)
    );

    fp_norm_round fp_norm_round_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .norm_en  (norm_en),
        .prod     (prod),
        .exp_sum  (exp_sum),
        .res_sign (res_sign),
        .spec     (spec),
        .result   (result)
    );

endmodule

`default_nettype wire

//--- hdl/fp_norm_round.sv
`default_nettype none

module fp_norm_round (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        norm_en,
    input  logic [fpmul_pkg::prod_w-1:0] prod,
    input  logic signed [9:0]           exp_sum,
    input  logic                        res_sign,
    input  fpmul_pkg::special_t         spec,
    output logic [31:0]                 result
);
    import fpmul_pkg::*;

    logic [5:0]         lz;
    logic [5:0]         rsh;
    logic [prod_w+63:0] wide;       // aligned product over the shifted-out bits
    logic [9:0]         e_field;    // 0 means subnormal scale
    logic [prod_w-1:0]  m;
    logic [sig_w-1:0]   kept;
    logic               guard, rnd, sticky, inc;
    logic [32:0]        rnd_word;   // exponent and fraction, carry runs into exponent
    logic [9:0]         rnd_exp;
    logic               ovf;
    fp32_t              res_w;

    function automatic logic [5:0] lead_zeros(input logic [prod_w-1:0] v);
        logic [5:0] n;
        logic       found;
        n = 6'd0;
        found = 1'b0;
        for (int i = prod_w - 1; i >= 0; i--) begin
            if (v[i])
                found = 1'b1;
            else if (!found)
                n = n + 6'd1;
        end
        return n;
    endfunction

    always_comb begin
        lz = lead_zeros(prod);
        rsh = 6'd0;
        if (exp_sum < 0) begin
            // below normal range, denormalize with sticky
            rsh = (exp_sum < -10'sd63) ? 6'd63 : 6'(-exp_sum);
            wide = {prod, 64'b0} >> rsh;
            e_field = 10'd0;
        end else if ($signed({4'b0000, lz}) <= exp_sum) begin
            wide = {prod << lz, 64'b0};
            e_field = 10'(exp_sum + 10'sd1 - $signed({4'b0000, lz}));
        end else begin
            wide = {prod << exp_sum[5:0], 64'b0};  // shift stops at exponent limit
            e_field = 10'd0;
        end
    end

    assign m      = wide[prod_w+63:64];
    assign kept   = m[prod_w-1:sig_w];
    assign guard  = m[sig_w-1];
    assign rnd    = m[sig_w-2];
    assign sticky = (|m[sig_w-3:0]) | (|wide[63:0]);
    assign inc    = guard && (rnd || sticky || kept[0]);  // nearest, ties to even

    assign rnd_word = {e_field, kept[man_w-1:0]} + 33'(inc);
    assign rnd_exp  = rnd_word[32:man_w];
    assign ovf      = (rnd_exp >= {2'b00, exp_max});

    always_comb begin
        res_w.fld.sign = res_sign;
        res_w.fld.exp  = 8'd0;
        res_w.fld.frac = '0;
        case (spec)
            res_nan: res_w.bits = qnan_word;
            res_inf: res_w.fld.exp = exp_max;
            res_zero: res_w.fld.exp = 8'd0;     // signed zero
            default: begin
                if (ovf) begin
                    res_w.fld.exp = exp_max;
                end else begin
                    res_w.fld.exp  = rnd_exp[7:0];
                    res_w.fld.frac = rnd_word[man_w-1:0];
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            result <= 32'd0;
        else if (norm_en)
            result <= res_w.bits;   // held until the next operation
    end

endmodule

`default_nettype wire

//--- hdl/man_shift_add.sv
`default_nettype none

module man_shift_add (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic                       run,
    input  logic [fpmul_pkg::sig_w-1:0]  sig_a,
    input  logic [fpmul_pkg::sig_w-1:0]  sig_b,
    output logic [fpmul_pkg::prod_w-1:0] prod
);
    import fpmul_pkg::*;

    logic [prod_w-1:0] acc;
    logic [sig_w-1:0]  mplr;       // multiplier, consumed lsb first
    logic              pick;       // unpack registers settle one edge after load
    logic [sig_w:0]    part_sum;   // upper half plus multiplicand, with carry

    assign part_sum = {1'b0, acc[prod_w-1:sig_w]} + (mplr[0] ? {1'b0, sig_a} : '0);
    assign prod     = acc;

    always_ff @(posedge clk) begin
        if (!rst_n)
            pick <= 1'b0;
        else
            pick <= load;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc <= '0;
        end else if (run) begin
            // carry drops into the top bit as everything moves right
            acc <= {part_sum, acc[sig_w-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (pick)
            mplr <= sig_b;
        else if (run)
            mplr <= mplr >> 1;
    end

endmodule

`default_nettype wire

//--- hdl/fp_unpack.sv
`default_nettype none

module fp_unpack (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,
    input  logic [31:0]               op_a,
    input  logic [31:0]               op_b,
    output logic [fpmul_pkg::sig_w-1:0] sig_a,
    output logic [fpmul_pkg::sig_w-1:0] sig_b,
    output logic                      res_sign,
    output logic signed [9:0]         exp_sum,
    output fpmul_pkg::special_t       spec
);
    import fpmul_pkg::*;

    fp32_t    a;
    fp32_t    b;
    logic     zero_a, zero_b;  // subnormals count as zero
    logic     inf_a, inf_b;
    logic     nan_a, nan_b;
    special_t spec_d;

    assign a.bits = op_a;
    assign b.bits = op_b;

    assign zero_a = (a.fld.exp == 8'd0);
    assign zero_b = (b.fld.exp == 8'd0);
    assign inf_a  = (a.fld.exp == exp_max) && (a.fld.frac == '0);
    assign inf_b  = (b.fld.exp == exp_max) && (b.fld.frac == '0);
    assign nan_a  = (a.fld.exp == exp_max) && (a.fld.frac != '0);
    assign nan_b  = (b.fld.exp == exp_max) && (b.fld.frac != '0);

    always_comb begin
        if (nan_a || nan_b || (inf_a && zero_b) || (zero_a && inf_b))
            spec_d = res_nan;
        else if (inf_a || inf_b)
            spec_d = res_inf;
        else if (zero_a || zero_b)
            spec_d = res_zero;
        else
            spec_d = none;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            spec <= none;
        else if (load)
            spec <= spec_d;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            sig_a    <= {1'b1, a.fld.frac};     // hidden bit
            sig_b    <= {1'b1, b.fld.frac};
            res_sign <= a.fld.sign ^ b.fld.sign;
            exp_sum  <= $signed({2'b00, a.fld.exp}) + $signed({2'b00, b.fld.exp})
                        - $signed({2'b00, exp_bias});
        end
    end

endmodule

`default_nettype wire

//--- hdl/iter_counter.sv
`default_nettype none

module iter_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic run,
    output logic last
);
    import fpmul_pkg::*;

    logic [4:0] cnt;

    assign last = run && (cnt == 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= 5'd0;
        end else if (load) begin
            cnt <= 5'(sig_w - 1);   // one step per significand bit
        end else if (run && cnt != 5'd0) begin
            cnt <= cnt - 5'd1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fpmul_ctrl.sv
`default_nettype none

module fpmul_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last,
    output logic load,
    output logic run,
    output logic norm_en,
    output logic busy,
    output logic done
);
    import fpmul_pkg::*;

    fpmul_state_t state;
    logic         prime;    // first mult cycle, datapath picks up operands

    assign busy    = (state == mult) || (state == norm);
    assign load    = start && !busy;    // idle or done_st accept a new start
    assign run     = (state == mult) && !prime;
    assign norm_en = (state == norm);
    assign done    = (state == done_st);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            prime <= 1'b0;
        end else begin
            prime <= load;
            case (state)
                idle: begin
                    if (load)
                        state <= mult;
                end
                mult: begin
                    if (last)
                        state <= norm;  // 24th iteration done
                end
                norm: begin
                    state <= done_st;
                end
                done_st: begin
                    // back to back operation possible
                    if (load)
                        state <= mult;
                    else
                        state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/fpmul_pkg.sv
`default_nettype none

package fpmul_pkg;

    // binary32 format
    localparam logic [7:0] exp_bias = 8'd127;
    localparam logic [7:0] exp_max  = 8'd255;   // inf / nan exponent
    localparam int man_w  = 23;                 // stored fraction bits
    localparam int sig_w  = 24;                 // with hidden bit
    localparam int prod_w = 48;                 // full significand product

    localparam logic [31:0] qnan_word = 32'h7fc0_0000;

    // fp32 word, seen either as raw bits or as its fields
    typedef struct packed {
        logic             sign;
        logic [7:0]       exp;
        logic [man_w-1:0] frac;
    } fp32_fields_t;

    typedef union packed {
        logic [31:0]  bits;
        fp32_fields_t fld;
    } fp32_t;

    typedef enum logic [1:0] {
        idle    = 2'd0,
        mult    = 2'd1,
        norm    = 2'd2,
        done_st = 2'd3
    } fpmul_state_t;

    // operand class decided at unpack time, applied at the end
    typedef enum logic [1:0] {
        none     = 2'd0,
        res_zero = 2'd1,
        res_inf  = 2'd2,
        res_nan  = 2'd3
    } special_t;

endpackage

`default_nettype wire
